/* hdl/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// processor bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64

// data RAM window, 32-bit words
`define RAM_BASE 32'h0000_1000
`define RAM_WORDS 512
// word index width, log2 of RAM_WORDS
`define RAM_WORD_W 9

// interrupt controller window
`define PLIC_BASE 32'h0C00_0000
// offset bits decoded inside the window
`define PLIC_OFS_W 22

// register offsets from PLIC_BASE
// priorities sit at 4 * id below the pending word
`define PLIC_PENDING_OFS 32'h0000_1000
`define PLIC_ENABLE_OFS 32'h0000_2000
`define PLIC_CTX_ENABLE_STRIDE 32'h0000_0080
`define PLIC_THRESH_OFS 32'h0020_0000
`define PLIC_CLAIM_OFS 32'h0020_0004
// threshold and claim step per context
`define PLIC_CTX_STRIDE 32'h0000_1000

// sources 1..5, id 0 means none
`define PLIC_SOURCES 5
`define PLIC_PRIO_W 3

`endif

/* hdl/soc_pkg.sv */
`default_nettype none

`include "soc_params.svh"

package soc_pkg;

    // one bus doubleword, or its two 32-bit halves
    // words[0] is the low half, words[1] the high half
    typedef union packed {
        logic [`SOC_DATA_W-1:0] dword;
        logic [`SOC_DATA_W/32-1:0][31:0] words;
    } bus_word_u;

    // load/store type on the bus
    // bit 2 set means zero extension
    // bits 1:0 give the size, byte/half/word/double
    // stores reuse 000..011 for sb, sh, sw and sd
    typedef enum logic [2:0] {
        LS_LB  = 3'b000,
        LS_LH  = 3'b001,
        LS_LW  = 3'b010,
        LS_LD  = 3'b011,
        LS_LBU = 3'b100,
        LS_LHU = 3'b101,
        LS_LWU = 3'b110
    } ls_type_e;

endpackage

`default_nettype wire

/* hdl/data_ram.sv */
`default_nettype none

`include "soc_params.svh"

`timescale 1ns/100ps

module data_ram (
    input wire CLOCK_50,
    input wire KEY0,
    input wire ram_rd_beat,
    input wire ram_wr_beat,
    input wire [`RAM_WORD_W-1:0] ram_word,
    input wire [1:0] ram_byte,
    input wire soc_pkg::ls_type_e ls_type,
    input wire soc_pkg::bus_word_u wdata,
    output soc_pkg::bus_word_u ram_rdata,
    output logic ram_last
);

    // little-endian words, byte 0 in bits 7:0
    logic [31:0] mem [`RAM_WORDS];

    // 0 on the low word, 1 on the high word of ld/sd
    logic beat;
    logic is_dw;
    logic [`RAM_WORD_W-1:0] addr;
    logic [31:0] rd_word;
    logic [31:0] lane;
    logic sx;
    logic [`SOC_DATA_W-1:0] ext;

    assign is_dw = (ls_type == soc_pkg::LS_LD);
    // second beat moves to the next word
    assign addr = ram_word + {{(`RAM_WORD_W-1){1'b0}}, beat};
    assign rd_word = mem[addr];

    // single beats end at once, doublewords on the second beat
    assign ram_last = (ram_rd_beat | ram_wr_beat) & (~is_dw | beat);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat <= 1'b0;
        end else if (ram_rd_beat || ram_wr_beat) begin
            beat <= is_dw & ~beat;
        end
    end

    // load lane down to bit 0
    assign lane = rd_word >> {ram_byte, 3'b000};
    // sign fill only for signed types
    assign sx = ~ls_type[2];

    always_comb begin
        case (ls_type[1:0])
            2'b00: ext = {{(`SOC_DATA_W-8){sx & lane[7]}}, lane[7:0]};
            2'b01: ext = {{(`SOC_DATA_W-16){sx & lane[15]}}, lane[15:0]};
            default: ext = {{(`SOC_DATA_W-32){sx & lane[31]}}, lane};
        endcase
    end

    // stores, byte and half go to their own lane
    always_ff @(posedge CLOCK_50) begin
        if (ram_wr_beat) begin
            case (ls_type[1:0])
                2'b00: mem[addr][{ram_byte, 3'b000} +: 8] <= wdata.dword[7:0];
                2'b01: mem[addr][{ram_byte[1], 4'b0000} +: 16] <= wdata.dword[15:0];
                2'b10: mem[addr] <= wdata.words[0];
                // sd, low half then high half
                default: mem[addr] <= wdata.words[beat];
            endcase
        end
    end

    // load register
    // ld fills one half per beat
    always_ff @(posedge CLOCK_50) begin
        if (ram_rd_beat) begin
            if (is_dw) begin
                ram_rdata.words[beat] <= rd_word;
            end else begin
                ram_rdata.dword <= ext;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/plic.sv */
`default_nettype none

`include "soc_params.svh"

`timescale 1ns/100ps

module plic (
    input wire CLOCK_50,
    input wire KEY0,
    input wire plic_rd,
    input wire plic_wr,
    input wire [`PLIC_OFS_W-1:0] plic_offset,
    input wire [31:0] wdata,
    output logic [31:0] plic_rdata,
    input wire [`PLIC_SOURCES-1:0] irq_src,
    output logic meip,
    output logic seip
);

    // ids 0..PLIC_SOURCES
    localparam int ID_W = $clog2(`PLIC_SOURCES + 1);

    // context 0 machine, context 1 supervisor
    logic [`PLIC_PRIO_W-1:0] prio [1:`PLIC_SOURCES];
    logic [`PLIC_SOURCES:1] pending;
    logic [`PLIC_SOURCES:1] enable [2];
    logic [`PLIC_PRIO_W-1:0] thresh [2];
    // last source levels for edge capture
    logic [`PLIC_SOURCES-1:0] irq_q;
    logic [`PLIC_SOURCES:1] src_rise;
    logic [`PLIC_SOURCES:1] claim_clr;

    logic [`SOC_ADDR_W-1:0] ofs;
    logic [9:0] prio_id;
    logic prio_hit;
    logic pend_hit;
    logic [1:0] en_hit;
    logic [1:0] th_hit;
    logic [1:0] cl_hit;

    // winner per context
    logic [ID_W-1:0] best_id [2];
    logic [`PLIC_PRIO_W-1:0] best_pri [2];

    // register decode
    assign ofs = {{(`SOC_ADDR_W-`PLIC_OFS_W){1'b0}}, plic_offset};
    assign prio_id = plic_offset[11:2];
    assign prio_hit = (ofs < `PLIC_PENDING_OFS) && (prio_id != 10'd0) &&
                      (prio_id <= 10'(`PLIC_SOURCES));
    assign pend_hit = (ofs == `PLIC_PENDING_OFS);

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            en_hit[c] = (ofs == `PLIC_ENABLE_OFS + c * `PLIC_CTX_ENABLE_STRIDE);
            th_hit[c] = (ofs == `PLIC_THRESH_OFS + c * `PLIC_CTX_STRIDE);
            cl_hit[c] = (ofs == `PLIC_CLAIM_OFS + c * `PLIC_CTX_STRIDE);
        end
    end

    // arbitration
    // strictly above threshold, ties go to the lower id
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            best_id[c] = '0;
            best_pri[c] = thresh[c];
            for (int s = 1; s <= `PLIC_SOURCES; s++) begin
                if (pending[s] && enable[c][s] && (prio[s] > best_pri[c])) begin
                    best_pri[c] = prio[s];
                    best_id[c] = ID_W'(s);
                end
            end
        end
    end

    assign meip = (best_id[0] != '0);
    assign seip = (best_id[1] != '0);

    // claim read drops the winner's pending bit
    always_comb begin
        claim_clr = '0;
        for (int c = 0; c < 2; c++) begin
            if (plic_rd && cl_hit[c] && (best_id[c] != '0)) begin
                claim_clr[best_id[c]] = 1'b1;
            end
        end
    end

    // source 1 sits on irq_src[0]
    assign src_rise = irq_src & ~irq_q;

    // read mux, zero-extended to 32 bits
    always_comb begin
        plic_rdata = '0;
        if (prio_hit) begin
            plic_rdata = {{(32-`PLIC_PRIO_W){1'b0}}, prio[prio_id[ID_W-1:0]]};
        end else if (pend_hit) begin
            plic_rdata = {{(31-`PLIC_SOURCES){1'b0}}, pending, 1'b0};
        end
        for (int c = 0; c < 2; c++) begin
            if (en_hit[c]) begin
                plic_rdata = {{(31-`PLIC_SOURCES){1'b0}}, enable[c], 1'b0};
            end
            if (th_hit[c]) begin
                plic_rdata = {{(32-`PLIC_PRIO_W){1'b0}}, thresh[c]};
            end
            if (cl_hit[c]) begin
                plic_rdata = {{(32-ID_W){1'b0}}, best_id[c]};
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int s = 1; s <= `PLIC_SOURCES; s++) begin
                prio[s] <= '0;
            end
            for (int c = 0; c < 2; c++) begin
                enable[c] <= '0;
                thresh[c] <= '0;
            end
            pending <= '0;
            irq_q <= '0;
        end else begin
            irq_q <= irq_src;
            // pending and claim ignore writes
            if (plic_wr) begin
                if (prio_hit) begin
                    prio[prio_id[ID_W-1:0]] <= wdata[`PLIC_PRIO_W-1:0];
                end
                for (int c = 0; c < 2; c++) begin
                    if (en_hit[c]) begin
                        enable[c] <= wdata[`PLIC_SOURCES:1];
                    end
                    if (th_hit[c]) begin
                        thresh[c] <= wdata[`PLIC_PRIO_W-1:0];
                    end
                end
            end
            // new edge beats a claim in the same cycle
            pending <= (pending & ~claim_clr) | src_rise;
        end
    end

endmodule

`default_nettype wire

/* hdl/mmio_responder.sv */
`default_nettype none

`include "soc_params.svh"

`timescale 1ns/100ps

module mmio_responder (
    input wire CLOCK_50,
    input wire KEY0,
    // processor bus
    input wire [`SOC_ADDR_W-1:0] bus_address,
    input wire bus_read_enable,
    input wire bus_write_enable,
    output logic [`SOC_DATA_W-1:0] bus_read_data,
    output logic bus_read_done,
    output logic bus_write_done,
    // beat and register strobes
    output logic ram_rd_beat,
    output logic ram_wr_beat,
    output logic plic_rd,
    output logic plic_wr,
    // forwarded offsets
    output logic [`RAM_WORD_W-1:0] ram_word,
    output logic [1:0] ram_byte,
    output logic [`PLIC_OFS_W-1:0] plic_offset,
    // returned data
    input wire soc_pkg::bus_word_u ram_rdata,
    input wire ram_last,
    input wire [31:0] plic_rdata
);

    logic [`SOC_ADDR_W-1:0] ram_ofs;
    logic [`SOC_ADDR_W-1:0] plic_ofs;
    logic ram_hit;
    logic plic_hit;
    // target of the access in flight
    logic sel_ram;
    // unmapped access, one cycle
    logic miss;
    // final beat done, done flags rise next edge
    logic fin;

    // window decode on the held address
    assign ram_hit = (bus_address >= `RAM_BASE) &&
                     (bus_address < `RAM_BASE + 4 * `RAM_WORDS);
    assign plic_hit = (bus_address >= `PLIC_BASE) &&
                      (bus_address < `PLIC_BASE + (32'd1 << `PLIC_OFS_W));

    // offsets into each window
    assign ram_ofs = bus_address - `RAM_BASE;
    assign plic_ofs = bus_address - `PLIC_BASE;
    assign ram_word = ram_ofs[`RAM_WORD_W+1:2];
    assign ram_byte = ram_ofs[1:0];
    assign plic_offset = plic_ofs[`PLIC_OFS_W-1:0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b1;
            bus_write_done <= 1'b1;
            ram_rd_beat <= 1'b0;
            ram_wr_beat <= 1'b0;
            plic_rd <= 1'b0;
            plic_wr <= 1'b0;
            sel_ram <= 1'b0;
            miss <= 1'b0;
            fin <= 1'b0;
        end else begin
            // controller and unmapped strobes last one cycle
            plic_rd <= 1'b0;
            plic_wr <= 1'b0;
            miss <= 1'b0;
            fin <= ram_last | plic_rd | plic_wr | miss;

            // RAM strobe repeats until the final beat
            if (ram_last) begin
                ram_rd_beat <= 1'b0;
                ram_wr_beat <= 1'b0;
            end

            if (fin) begin
                bus_read_done <= 1'b1;
                bus_write_done <= 1'b1;
            end

            // enable only arrives while both flags are high
            if (bus_read_enable || bus_write_enable) begin
                sel_ram <= ram_hit;
                ram_rd_beat <= bus_read_enable & ram_hit;
                ram_wr_beat <= bus_write_enable & ram_hit;
                plic_rd <= bus_read_enable & plic_hit;
                plic_wr <= bus_write_enable & plic_hit;
                miss <= ~ram_hit & ~plic_hit;
                if (bus_read_enable) begin
                    bus_read_done <= 1'b0;
                end
                if (bus_write_enable) begin
                    bus_write_done <= 1'b0;
                end
            end
        end
    end

    // read data
    // claim clears pending at the strobe edge, so grab it then
    always_ff @(posedge CLOCK_50) begin
        if (plic_rd) begin
            bus_read_data <= {{(`SOC_DATA_W-32){1'b0}}, plic_rdata};
        end else if (miss && !bus_read_done) begin
            bus_read_data <= '0;
        end else if (fin && sel_ram && !bus_read_done) begin
            bus_read_data <= ram_rdata.dword;
        end
    end

endmodule

`default_nettype wire

/* hdl/mmio_subsystem.sv */
`default_nettype none

`include "soc_params.svh"

`timescale 1ns/100ps

module mmio_subsystem (
    input wire CLOCK_50,
    input wire KEY0,
    // processor bus, slave side
    input wire [`SOC_ADDR_W-1:0] bus_address,
    input wire soc_pkg::ls_type_e bus_ls_type,
    input wire [`SOC_DATA_W-1:0] bus_write_data,
    input wire bus_read_enable,
    input wire bus_write_enable,
    output logic [`SOC_DATA_W-1:0] bus_read_data,
    output logic bus_read_done,
    output logic bus_write_done,
    // interrupt sources and per-context lines
    input wire [`PLIC_SOURCES-1:0] irq_src,
    output logic meip,
    output logic seip
);

    // responder to RAM
    wire ram_rd_beat;
    wire ram_wr_beat;
    wire [`RAM_WORD_W-1:0] ram_word;
    wire [1:0] ram_byte;
    wire soc_pkg::bus_word_u ram_rdata;
    wire ram_last;

    // responder to interrupt controller
    wire plic_rd;
    wire plic_wr;
    wire [`PLIC_OFS_W-1:0] plic_offset;
    wire [31:0] plic_rdata;

    // decode, done flags, read data
    mmio_responder i_responder (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus_address    (bus_address),
        .bus_read_enable(bus_read_enable),
        .bus_write_enable(bus_write_enable),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done),
        .ram_rd_beat    (ram_rd_beat),
        .ram_wr_beat    (ram_wr_beat),
        .plic_rd        (plic_rd),
        .plic_wr        (plic_wr),
        .ram_word       (ram_word),
        .ram_byte       (ram_byte),
        .plic_offset    (plic_offset),
        .ram_rdata      (ram_rdata),
        .ram_last       (ram_last),
        .plic_rdata     (plic_rdata)
    );

    // type and store data come straight off the bus, held by the master
    data_ram i_ram (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .ram_rd_beat(ram_rd_beat),
        .ram_wr_beat(ram_wr_beat),
        .ram_word   (ram_word),
        .ram_byte   (ram_byte),
        .ls_type    (bus_ls_type),
        .wdata      (bus_write_data),
        .ram_rdata  (ram_rdata),
        .ram_last   (ram_last)
    );

    // controller registers are 32 bits wide
    plic i_plic (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .plic_rd    (plic_rd),
        .plic_wr    (plic_wr),
        .plic_offset(plic_offset),
        .wdata      (bus_write_data[31:0]),
        .plic_rdata (plic_rdata),
        .irq_src    (irq_src),
        .meip       (meip),
        .seip       (seip)
    );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

`timescale 1ns/100ps

module tb_clock (
    output logic CLOCK_50,
    output logic KEY0
);

    // 100 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // reset held low for 8 cycles, released just after an edge
    initial begin
        KEY0 = 1'b0;
        repeat (8) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_top.sv */
`default_nettype none

`include "soc_params.svh"

`timescale 1ns/100ps

module tb_top;

    // bus transactions per test set the run limit
    localparam int SIZED_OPS = 200;
    localparam int DW_ROUNDS = 20;
    localparam int ARB_ROUNDS = 8;
    localparam int TOTAL_OPS = `RAM_WORDS + SIZED_OPS + DW_ROUNDS * 4 + 40 + ARB_ROUNDS * 36;
    // at most 4 cycles per transaction
    localparam int CYCLE_LIMIT = TOTAL_OPS * 4 + 200;

    wire CLOCK_50;
    wire KEY0;
    logic [`SOC_ADDR_W-1:0] bus_address;
    soc_pkg::ls_type_e bus_ls_type;
    logic [`SOC_DATA_W-1:0] bus_write_data;
    logic bus_read_enable;
    logic bus_write_enable;
    wire [`SOC_DATA_W-1:0] bus_read_data;
    wire bus_read_done;
    wire bus_write_done;
    logic [`PLIC_SOURCES-1:0] irq_src;
    wire meip;
    wire seip;

    // reference model of the RAM bytes and controller registers
    logic [7:0] ram_m [4*`RAM_WORDS];
    logic [`PLIC_PRIO_W-1:0] prio_m [1:`PLIC_SOURCES];
    logic [`PLIC_SOURCES:0] en_m [2];
    logic [`PLIC_PRIO_W-1:0] th_m [2];
    // bit 0 unused as in the register layout
    logic [`PLIC_SOURCES:0] pend_m;

    logic [31:0] seed;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    tb_clock i_clock (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0)
    );

    mmio_subsystem i_dut (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_address     (bus_address),
        .bus_ls_type     (bus_ls_type),
        .bus_write_data  (bus_write_data),
        .bus_read_enable (bus_read_enable),
        .bus_write_enable(bus_write_enable),
        .bus_read_data   (bus_read_data),
        .bus_read_done   (bus_read_done),
        .bus_write_done  (bus_write_done),
        .irq_src         (irq_src),
        .meip            (meip),
        .seip            (seip)
    );

    // run limit
    always @(posedge CLOCK_50) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // LCG with the upper half folded into the lower half
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[31:16], seed[31:16] ^ seed[15:0]};
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    function automatic logic done_flag(input logic wr);
        return wr ? bus_write_done : bus_read_done;
    endfunction

    // one access starting and ending 2 ns after an edge
    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [2:0] t,
                              input logic [63:0] wdata, output logic [63:0] rdata,
                              output int edges);
        edges = 0;
        bus_address = addr;
        bus_ls_type = soc_pkg::ls_type_e'(t);
        bus_write_data = wdata;
        bus_read_enable = ~wr;
        bus_write_enable = wr;
        @(posedge CLOCK_50);
        #2;
        bus_read_enable = 1'b0;
        bus_write_enable = 1'b0;
        // done drops at the enable edge
        check_value(wr ? "bus_write_done" : "bus_read_done", 64'd0, {63'd0, done_flag(wr)});
        do begin
            @(posedge CLOCK_50);
            #2;
            edges++;
        end while (!done_flag(wr));
        rdata = bus_read_data;
    endtask

    // expected load from little-endian bytes
    // sign fill unless bit 2 set
    function automatic logic [63:0] expect_load(input int ofs, input logic [2:0] t);
        logic [63:0] raw;
        int n;
        raw = '0;
        n = 1 << t[1:0];
        for (int i = 0; i < n; i++) begin
            raw[8*i +: 8] = ram_m[ofs + i];
        end
        if (!t[2] && n < 8 && raw[8*n-1]) begin
            raw = raw | (~64'd0 << (8 * n));
        end
        return raw;
    endfunction

    // ld/sd take one more edge
    function automatic logic [63:0] done_edges(input logic [2:0] t);
        return (t[1:0] == 2'b11) ? 64'd3 : 64'd2;
    endfunction

    task automatic ram_store(input int ofs, input logic [2:0] t, input logic [63:0] d);
        logic [63:0] rd;
        int edges;
        bus_access(1'b1, `RAM_BASE + ofs, t, d, rd, edges);
        for (int i = 0; i < (1 << t[1:0]); i++) begin
            ram_m[ofs + i] = d[8*i +: 8];
        end
        check_value("bus_write_done edge count", done_edges(t), 64'(edges));
    endtask

    task automatic ram_load(input int ofs, input logic [2:0] t);
        logic [63:0] rd;
        int edges;
        bus_access(1'b0, `RAM_BASE + ofs, t, 64'd0, rd, edges);
        check_value("bus_read_data", expect_load(ofs, t), rd);
        check_value("bus_read_done edge count", done_edges(t), 64'(edges));
    endtask

    task automatic reg_write(input logic [31:0] ofs, input logic [31:0] d);
        logic [63:0] rd;
        int edges;
        bus_access(1'b1, `PLIC_BASE + ofs, 3'b010, {32'd0, d}, rd, edges);
        check_value("bus_write_done edge count", 64'd2, 64'(edges));
    endtask

    // register reads come back zero-extended
    task automatic reg_check(input logic [31:0] addr, input logic [31:0] exp);
        logic [63:0] rd;
        int edges;
        bus_access(1'b0, addr, 3'b010, 64'd0, rd, edges);
        check_value("bus_read_data", {32'd0, exp}, rd);
        check_value("bus_read_done edge count", 64'd2, 64'(edges));
    endtask

    // one-cycle pulse on the source lines
    // pending sets at the next edge
    task automatic pulse_sources(input logic [`PLIC_SOURCES-1:0] lines);
        irq_src = lines;
        @(posedge CLOCK_50);
        #2;
        irq_src = '0;
        pend_m = pend_m | {lines, 1'b0};
    endtask

    function automatic logic [31:0] enable_ofs(input int c);
        return `PLIC_ENABLE_OFS + 32'(c) * `PLIC_CTX_ENABLE_STRIDE;
    endfunction

    function automatic logic [31:0] thresh_ofs(input int c);
        return `PLIC_THRESH_OFS + 32'(c) * `PLIC_CTX_STRIDE;
    endfunction

    function automatic logic [31:0] claim_ofs(input int c);
        return `PLIC_CLAIM_OFS + 32'(c) * `PLIC_CTX_STRIDE;
    endfunction

    function automatic logic eligible(input int c, input int s);
        return pend_m[s] && en_m[c][s] && (prio_m[s] > th_m[c]);
    endfunction

    // top priority first and then the lowest id holding it
    function automatic logic [2:0] winner(input int c);
        logic [`PLIC_PRIO_W-1:0] top;
        logic any;
        logic [2:0] id;
        top = '0;
        any = 1'b0;
        id = 3'd0;
        for (int s = 1; s <= `PLIC_SOURCES; s++) begin
            if (eligible(c, s) && (!any || prio_m[s] > top)) begin
                top = prio_m[s];
                any = 1'b1;
            end
        end
        // downward scan leaves the lowest id
        for (int s = `PLIC_SOURCES; s >= 1; s--) begin
            if (any && eligible(c, s) && prio_m[s] == top) begin
                id = 3'(s);
            end
        end
        return id;
    endfunction

    task automatic check_lines();
        check_value("meip", {63'd0, winner(0) != 3'd0}, {63'd0, meip});
        check_value("seip", {63'd0, winner(1) != 3'd0}, {63'd0, seip});
    endtask

    // claim and then check that pending shows the bit gone
    task automatic claim_check(input int c, output logic [2:0] id);
        id = winner(c);
        reg_check(`PLIC_BASE + claim_ofs(c), {29'd0, id});
        if (id != 3'd0) begin
            pend_m[id] = 1'b0;
        end
        reg_check(`PLIC_BASE + `PLIC_PENDING_OFS, {26'd0, pend_m});
        check_lines();
    endtask

    task automatic program_prio(input int s);
        logic [31:0] r;
        r = next_random();
        reg_write(32'(4 * s), r);
        prio_m[s] = r[`PLIC_PRIO_W-1:0];
    endtask

    task automatic report_test(input string name, input int first);
        $display("test %s done, %0d errors", name, errors - first);
    endtask

    initial begin
        int first;
        int ofs;
        int sel;
        logic [31:0] r;
        logic [63:0] d;
        logic [63:0] rd;
        int edges;
        logic [2:0] id;
        int j;

        seed = 32'h6a08;
        bus_address = '0;
        bus_ls_type = soc_pkg::LS_LW;
        bus_write_data = '0;
        bus_read_enable = 1'b0;
        bus_write_enable = 1'b0;
        irq_src = '0;
        pend_m = '0;
        wait (KEY0 === 1'b1);

        first = errors;
        check_value("bus_read_done", 64'd1, {63'd0, bus_read_done});
        check_value("bus_write_done", 64'd1, {63'd0, bus_write_done});
        check_value("meip", 64'd0, {63'd0, meip});
        check_value("seip", 64'd0, {63'd0, seip});
        report_test("reset state", first);

        first = errors;
        // known contents first with a pattern over the whole word index
        for (int i = 0; i < `RAM_WORDS; i++) begin
            ram_store(4 * i, 3'b010, {32'd0, 32'h9e37_79b9 * 32'(i + 1)});
        end
        for (int k = 0; k < SIZED_OPS; k++) begin
            sel = int'(next_random() % 32'd10);
            r = next_random();
            d = {next_random(), next_random()};
            // 0..2 give stores sb/sh/sw and 3..9 the seven loads
            if (sel < 3) begin
                ofs = int'(r[10:0]) & ~((1 << sel) - 1);
                ram_store(ofs, 3'(sel), d);
            end else begin
                ofs = int'(r[10:0]) & ~((1 << (sel - 3) % 4) - 1);
                ram_load(ofs, 3'(sel - 3));
            end
        end
        report_test("sized RAM traffic", first);

        first = errors;
        for (int k = 0; k < DW_ROUNDS; k++) begin
            r = next_random();
            ofs = int'(r[10:3]) * 8;
            ram_store(ofs, 3'b011, {next_random(), next_random()});
            ram_load(ofs, 3'b011);
            // neighbors untouched
            if (ofs >= 4) begin
                ram_load(ofs - 4, 3'b110);
            end
            if (ofs + 8 < 4 * `RAM_WORDS) begin
                ram_load(ofs + 8, 3'b110);
            end
        end
        report_test("doubleword traffic", first);

        first = errors;
        for (int s = 1; s <= `PLIC_SOURCES; s++) begin
            program_prio(s);
            reg_check(`PLIC_BASE + 32'(4 * s), {29'd0, prio_m[s]});
        end
        for (int c = 0; c < 2; c++) begin
            r = next_random();
            reg_write(enable_ofs(c), r);
            en_m[c] = {r[`PLIC_SOURCES:1], 1'b0};
            reg_check(`PLIC_BASE + enable_ofs(c), {26'd0, en_m[c]});
            r = next_random();
            reg_write(thresh_ofs(c), r);
            th_m[c] = r[`PLIC_PRIO_W-1:0];
            reg_check(`PLIC_BASE + thresh_ofs(c), {29'd0, th_m[c]});
        end
        // every source pending so a stray pending or claim write shows up
        pulse_sources('1);
        // pending and claim are read-only
        reg_write(`PLIC_PENDING_OFS, next_random());
        reg_write(claim_ofs(0), next_random());
        reg_write(claim_ofs(1), next_random());
        reg_check(`PLIC_BASE + `PLIC_PENDING_OFS, {26'd0, pend_m});
        for (int c = 0; c < 2; c++) begin
            reg_check(`PLIC_BASE + enable_ofs(c), {26'd0, en_m[c]});
            reg_check(`PLIC_BASE + thresh_ofs(c), {29'd0, th_m[c]});
        end
        // unmapped window
        for (int k = 0; k < 4; k++) begin
            // nonzero RAM word on the read bus first
            ram_load(4 * k, 3'b010);
            r = next_random();
            reg_check({6'b010000, r[25:2], 2'b00}, 32'd0);
        end
        report_test("controller registers", first);

        first = errors;
        for (int k = 0; k < ARB_ROUNDS; k++) begin
            for (int s = 1; s <= `PLIC_SOURCES; s++) begin
                program_prio(s);
            end
            for (int c = 0; c < 2; c++) begin
                r = next_random();
                reg_write(enable_ofs(c), r);
                en_m[c] = {r[`PLIC_SOURCES:1], 1'b0};
                r = next_random();
                // low thresholds so something usually fires
                reg_write(thresh_ofs(c), {30'd0, r[1:0]});
                th_m[c] = {1'b0, r[1:0]};
            end
            r = next_random();
            pulse_sources(r[`PLIC_SOURCES-1:0]);
            check_lines();
            for (int c = 0; c < 2; c++) begin
                j = 0;
                do begin
                    claim_check(c, id);
                    j++;
                end while (id != 3'd0 && j < `PLIC_SOURCES + 1);
            end
            check_value("meip", 64'd0, {63'd0, meip});
            check_value("seip", 64'd0, {63'd0, seip});
        end
        report_test("arbitration and claim", first);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hdl
hdl/soc_pkg.sv
hdl/data_ram.sv
hdl/plic.sv
hdl/mmio_responder.sv
hdl/mmio_subsystem.sv
sim/tb_clock.sv
sim/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the MMIO subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_top \
    -f src.f \
    -o tb_top_sim

./obj_dir/tb_top_sim | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail"
    exit 1
fi
